// File: adc_top.f
+incdir+verilog
verilog/adc_pkg.sv
verilog/adc_ifs.sv
verilog/mcu_bus_regs.sv
verilog/acq_ctrl.sv
verilog/ad7606_reader.sv
verilog/sample_fifo.sv
verilog/phase_meter.sv
verilog/adc_top.sv
testbench/tb_adc_top.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of tb_adc_top, passes only when the pass line is printed
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f adc_top.f --top-module tb_adc_top

result=$(./obj_dir/Vtb_adc_top 2>&1) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'All tests passed!'; then
    exit 0
fi
exit 1

// File: testbench/tb_adc_top.sv
// random stimulus from $urandom seed 17, converters are modelled here, assertions need --assert
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module tb_adc_top;
    import adc_pkg::*;

    localparam int     N_CH        = `ADC_CHIPS * `ADC_CHANS_PER_CHIP;
    localparam int     ACQ_DIV     = 63;                 // 64 clocks per conversion
    localparam longint WATCHDOG_NS = 64'd4 * N_CH * `FIFO_DEPTH * (ACQ_DIV + 1) * 20;

    logic       AD_CLK_40M = 1'b0;
    logic       rst_n      = 1'b0;
    logic       mcu_cs_n   = 1'b1;
    logic       mcu_we_n   = 1'b1;
    logic       mcu_rd_n   = 1'b1;
    addr_t      mcu_addr   = '0;
    word_t      mcu_wdata  = '0;
    word_t      mcu_rdata;
    logic       mcu_oe;
    sample_t    adc_db [`ADC_CHIPS] = '{default: '0};  // converter data buses
    logic [1:0] adc_busy   = 2'b00;
    logic [1:0] adc_convst;
    logic [1:0] adc_cs_n;
    logic [1:0] adc_rd_n;
    logic [1:0] adc_reset;
    logic       phase_in   = 1'b0;

    // --------------------
    // model state
    sample_t    exp_q [N_CH][$];                     // expected samples per channel
    int         busy_left [`ADC_CHIPS];              // busy clocks still to go
    int         rd_cnt [`ADC_CHIPS];                 // channel within conversion
    logic [1:0] convst_q = 2'b11;                    // last seen convst
    logic [1:0] rd_q     = 2'b11;                    // last seen rd_n
    int         phase_p;                             // 0 keeps phase_in still
    int         errors;

    adc_top u_dut (
        .AD_CLK_40M    (AD_CLK_40M),
        .rst_n         (rst_n),
        .mcu_cs_n_i    (mcu_cs_n),
        .mcu_we_n_i    (mcu_we_n),
        .mcu_rd_n_i    (mcu_rd_n),
        .mcu_addr_i    (mcu_addr),
        .mcu_data_i    (mcu_wdata),
        .mcu_data_o    (mcu_rdata),
        .mcu_data_oe_o (mcu_oe),
        .adc_db0_i     (adc_db[0]),
        .adc_db1_i     (adc_db[1]),
        .adc_busy_i    (adc_busy),
        .adc_convst_a_o(adc_convst),
        .adc_cs_n_o    (adc_cs_n),
        .adc_rd_n_o    (adc_rd_n),
        .adc_reset_o   (adc_reset),
        .phase_in_i    (phase_in)
    );

    always #10 AD_CLK_40M = ~AD_CLK_40M;             // 20 ns period

    task automatic wait_clocks(input int n);
        repeat (n) @(posedge AD_CLK_40M);
        #2;                                          // drive point after the edge
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_sample(input string name, input sample_t got, input sample_t exp);
        if (got !== exp) begin
            report_failure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // --------------------
    // MCU bus accesses
    task automatic bus_write(input addr_t addr, input word_t data);
        mcu_addr  = addr;
        mcu_wdata = data;
        mcu_cs_n  = 1'b0;
        mcu_we_n  = 1'b0;
        wait_clocks(4);                              // strobe held 4 clocks
        mcu_cs_n  = 1'b1;
        mcu_we_n  = 1'b1;
        wait_clocks(4);
    endtask

    task automatic bus_read(input addr_t addr, output word_t data);
        mcu_addr = addr;
        mcu_cs_n = 1'b0;
        mcu_rd_n = 1'b0;
        wait_clocks(4);
        data = mcu_rdata;                            // comb path, long settled
        check_word("mcu_data_oe_o", word_t'(mcu_oe), 16'h0001);
        mcu_cs_n = 1'b1;
        mcu_rd_n = 1'b1;
        wait_clocks(4);                              // addr held past the pop
        check_word("mcu_data_oe_o", word_t'(mcu_oe), 16'h0000);
    endtask

    task automatic read_check(input addr_t addr, input word_t exp, input string name);
        word_t got;
        bus_read(addr, got);
        check_word(name, got, exp);
    endtask

    // full flag per channel as the model sees it
    function automatic word_t full_flags();
        word_t f;
        f = '0;
        for (int ch = 0; ch < N_CH; ch++) begin
            f[ch] = (exp_q[ch].size() == `FIFO_DEPTH);
        end
        return f;
    endfunction

    task automatic run_acquisition();
        word_t got;
        bus_write(`ADDR_AD_ENABLE, 16'h0000);
        bus_write(`ADDR_AD_ENABLE, 16'h0001);        // rising edge starts a run
        got = '0;
        while (got[0] == 1'b0) begin
            bus_read(`ADDR_DATAFULL, got);           // poll data_full
        end
        read_check(`ADDR_STATUS, full_flags(), "status");
    endtask

    task automatic check_readout();
        word_t got;
        addr_t addr;
        for (int ch = 0; ch < N_CH; ch++) begin
            addr = addr_t'(`ADDR_CH1_DATA + 2 * ch);
            for (int n = 0; n < `FIFO_DEPTH; n++) begin
                if (exp_q[ch].size() == 0) begin
                    report_failure($sformatf("no expected sample left for channel %0d", ch + 1));
                end
                bus_read(addr, got);
                check_sample($sformatf("ch%0d data", ch + 1), sample_t'(got),
                             exp_q[ch].pop_front());
            end
            read_check(addr, 16'h0000, $sformatf("ch%0d data when empty", ch + 1));
        end
    endtask

    // --------------------
    // converter model, both chips
    always @(posedge AD_CLK_40M) begin
        int lane;
        #2;
        for (int c = 0; c < `ADC_CHIPS; c++) begin
            if (busy_left[c] > 0) begin
                busy_left[c]--;
                adc_busy[c] = (busy_left[c] != 0);   // drop after last busy clock
            end
            if (convst_q[c] && !adc_convst[c]) begin
                busy_left[c] = $urandom_range(20, 5);
                adc_busy[c]  = 1'b1;
                rd_cnt[c]    = 0;                    // new conversion
            end
            if (rd_q[c] && !adc_rd_n[c]) begin
                if (rd_cnt[c] >= `ADC_CHANS_PER_CHIP) begin
                    report_failure($sformatf("chip %0d read more than four channels", c));
                end
                check_word($sformatf("adc_cs_n_o[%0d]", c), word_t'(adc_cs_n[c]), 16'h0000);
                adc_db[c] = sample_t'($urandom);     // fresh value per strobe
                lane      = c * `ADC_CHANS_PER_CHIP + rd_cnt[c];
                if (exp_q[lane].size() < `FIFO_DEPTH) begin
                    exp_q[lane].push_back(adc_db[c]); // full queue drops it
                end
                rd_cnt[c]++;
            end
            convst_q[c] = adc_convst[c];
            rd_q[c]     = adc_rd_n[c];
        end
    end

    // key-phase source, period phase_p clocks
    always begin
        if (phase_p == 0) begin
            @(posedge AD_CLK_40M);
        end else begin
            repeat (phase_p / 2) @(posedge AD_CLK_40M);
            #2 phase_in = ~phase_in;
            repeat (phase_p - phase_p / 2) @(posedge AD_CLK_40M);
            #2 phase_in = ~phase_in;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        report_failure($sformatf("watchdog expired after %0d ns, run did not finish",
                                 WATCHDOG_NS));
    end

    initial begin
        word_t   w;
        period_t p;
        void'($urandom(17));
        phase_p = 0;
        errors  = 0;
        repeat (2) @(posedge AD_CLK_40M);            // reset for 2 cycles
        #2 rst_n = 1'b1;
        wait_clocks(2);

        // reset state and fixed registers
        check_word("adc_convst_a_o", word_t'(adc_convst), 16'h0003);
        check_word("adc_cs_n_o", word_t'(adc_cs_n), 16'h0003);
        check_word("adc_rd_n_o", word_t'(adc_rd_n), 16'h0003);
        check_word("adc_reset_o", word_t'(adc_reset), 16'h0000);
        read_check(`ADDR_VERSION, `REG_VERSION_VAL, "version");
        read_check(`ADDR_FREQ1, `FREQ1_RESET, "freq1");
        read_check(`ADDR_DATAFULL, 16'h0002, "datafull");  // no phase yet, error set
        w = word_t'($urandom);
        bus_write(`ADDR_FREQ1, w);
        read_check(`ADDR_FREQ1, w, "freq1");

        // --------------------
        // key-phase period
        phase_p = $urandom_range(200, 40);
        p       = period_t'(phase_p);
        wait_clocks(3 * phase_p + 8);                // two rising edges at least
        read_check(`ADDR_PHASE_L, p[15:0], "phase low");
        read_check(`ADDR_PHASE_H, p[31:16], "phase high");
        read_check(`ADDR_DATAFULL, 16'h0000, "datafull");

        // --------------------
        // acquisition, readout, clear and rerun
        bus_write(`ADDR_FREQ1, word_t'(ACQ_DIV));
        run_acquisition();
        check_readout();
        bus_write(`ADDR_FIFO_CLR, 16'h0001);
        bus_write(`ADDR_FIFO_CLR, 16'h0000);
        for (int ch = 0; ch < N_CH; ch++) begin
            exp_q[ch].delete();                      // queues emptied by clear
        end
        read_check(`ADDR_DATAFULL, 16'h0000, "datafull");
        read_check(`ADDR_STATUS, 16'h0000, "status");
        run_acquisition();
        check_readout();

        // converter reset follows bit 0
        w    = word_t'($urandom);
        w[0] = 1'b1;
        bus_write(`ADDR_AD_RESET, w);
        check_word("adc_reset_o", word_t'(adc_reset), word_t'({2{w[0]}}));
        w    = word_t'($urandom);
        w[0] = 1'b0;
        bus_write(`ADDR_AD_RESET, w);
        check_word("adc_reset_o", word_t'(adc_reset), word_t'({2{w[0]}}));

        if (errors == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            $display("Test failures found");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

// File: verilog/acq_ctrl.sv
// a run starts only on a fresh 0 to 1 of ad_enable and stops once data_full is set
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module acq_ctrl #(
    parameter int N_CH = `ADC_CHIPS * `ADC_CHANS_PER_CHIP
) (
    input  wire logic            AD_CLK_40M,
    input  wire logic            rst_n,
    acq_ctrl_if.ctrl_mp          ctrl,
    input  wire logic [N_CH-1:0] fifo_full_i,
    output logic                 start_o
);
    import adc_pkg::*;

    logic  en_d;                            // enable one cycle back
    word_t div_cnt;                         // free-running rate counter

    always_ff @(posedge AD_CLK_40M) begin
        if (!rst_n) begin
            en_d           <= 1'b0;
            ctrl.work_en   <= 1'b0;
            ctrl.data_full <= 1'b0;
            div_cnt        <= '0;
            start_o        <= 1'b0;
        end else begin
            en_d <= ctrl.ad_enable;

            // --------------------
            // run window
            if (ctrl.data_full) begin
                ctrl.work_en <= 1'b0;                       // stop on full
            end else if (ctrl.ad_enable && !en_d) begin
                ctrl.work_en <= 1'b1;                       // enable rising edge
            end

            // full latch, clear wins
            if (ctrl.fifo_clr) begin
                ctrl.data_full <= 1'b0;
            end else if (&fifo_full_i) begin
                ctrl.data_full <= 1'b1;
            end

            // start every freq_div+1 clocks
            start_o <= 1'b0;
            if (!ctrl.work_en) begin
                div_cnt <= '0;
            end else if (div_cnt == ctrl.freq_div) begin
                div_cnt <= '0;
                start_o <= !ctrl.data_full;                 // none in the stop cycle
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    a_start_in_run: assert property (@(posedge AD_CLK_40M) disable iff (!rst_n)
        $rose(start_o) |-> ctrl.work_en);

endmodule

`default_nettype wire

// File: verilog/ad7606_reader.sv
// waits without timeout for busy to rise and fall, and a start while busy is dropped
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module ad7606_reader (
    input  wire logic             AD_CLK_40M,
    input  wire logic             rst_n,
    input  wire logic             start_i,
    input  wire adc_pkg::sample_t adc_db_i,
    input  wire logic             adc_busy_i,
    output logic                  adc_convst_a_o,
    output logic                  adc_cs_n_o,
    output logic                  adc_rd_n_o,
    sample_if.src_mp              out
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_CONVST,                           // convst held low
        S_WAIT_HI,                          // wait busy rise
        S_WAIT_LO,                          // wait busy fall
        S_READ,                             // cs_n/rd_n low
        S_GAP                               // one high cycle between channels
    } state_t;

    state_t     state;
    logic [3:0] cnt;                        // strobe width counter
    logic [1:0] ch;                         // channel being read
    logic       last_rd;

    assign last_rd = (state == S_READ) && (cnt == 4'(`RD_CYCLES - 1));

    always_ff @(posedge AD_CLK_40M) begin
        if (!rst_n) begin
            state          <= S_IDLE;
            cnt            <= '0;
            ch             <= '0;
            adc_convst_a_o <= 1'b1;
            adc_cs_n_o     <= 1'b1;
            adc_rd_n_o     <= 1'b1;
            out.valid      <= 1'b0;
        end else begin
            out.valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_i) begin
                        adc_convst_a_o <= 1'b0;             // start conversion
                        cnt            <= '0;
                        state          <= S_CONVST;
                    end
                end
                S_CONVST: begin
                    if (cnt == 4'(`CONVST_CYCLES - 1)) begin
                        adc_convst_a_o <= 1'b1;
                        state          <= S_WAIT_HI;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_WAIT_HI: if (adc_busy_i) state <= S_WAIT_LO;
                S_WAIT_LO: begin
                    if (!adc_busy_i) begin
                        adc_cs_n_o <= 1'b0;                 // first channel
                        adc_rd_n_o <= 1'b0;
                        cnt        <= '0;
                        ch         <= '0;
                        state      <= S_READ;
                    end
                end
                S_READ: begin
                    if (last_rd) begin
                        adc_cs_n_o <= 1'b1;
                        adc_rd_n_o <= 1'b1;
                        if (ch == 2'(`ADC_CHANS_PER_CHIP - 1)) begin
                            out.valid <= 1'b1;              // all lanes captured
                            state     <= S_IDLE;
                        end else begin
                            ch    <= ch + 1'b1;
                            state <= S_GAP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_GAP: begin
                    adc_cs_n_o <= 1'b0;                     // next channel
                    adc_rd_n_o <= 1'b0;
                    cnt        <= '0;
                    state      <= S_READ;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // sample on the last low cycle of rd_n
    always_ff @(posedge AD_CLK_40M) begin
        if (last_rd) begin
            out.samples[ch] <= adc_db_i;
        end
    end

    // capture inside the strobe, and rd_n low only under cs_n
    a_rd_in_cs: assert property (@(posedge AD_CLK_40M) disable iff (!rst_n)
        (last_rd || !adc_rd_n_o) |-> (!adc_rd_n_o && !adc_cs_n_o));

endmodule

`default_nettype wire

// File: verilog/adc_defs.svh
// register map uses even offsets on a 9-bit MCU address and FIFO_DEPTH must be a power of two
`ifndef ADC_DEFS_SVH
`define ADC_DEFS_SVH

// --------------------
// channel layout
`define ADC_CHIPS           2               // converters on the board
`define ADC_CHANS_PER_CHIP  4               // channels read per conversion
`define FIFO_DEPTH          16              // entries per channel queue

// --------------------
// register map
`define REG_VERSION_VAL     16'h1000        // fixed version word
`define ADDR_VERSION        9'h000
`define ADDR_FREQ1          9'h002          // conversion divider
`define ADDR_PHASE_L        9'h00A          // key-phase period low half
`define ADDR_PHASE_H        9'h00C          // key-phase period high half
`define ADDR_AD_ENABLE      9'h00E          // rising edge starts a run
`define ADDR_AD_RESET       9'h010
`define ADDR_FIFO_CLR       9'h012          // level, holds queues empty
`define ADDR_STATUS         9'h014          // per-queue full flags
`define ADDR_CH1_DATA       9'h016          // first channel queue
`define ADDR_CH2_DATA       9'h018
`define ADDR_CH3_DATA       9'h01A
`define ADDR_CH4_DATA       9'h01C
`define ADDR_CH5_DATA       9'h01E
`define ADDR_CH6_DATA       9'h020
`define ADDR_CH7_DATA       9'h022
`define ADDR_CH8_DATA       9'h024          // last channel queue
`define ADDR_DATAFULL       9'h036          // data_full and detect_error

// --------------------
// converter timing in clocks
`define CONVST_CYCLES       2               // convst low width
`define RD_CYCLES           2               // cs_n/rd_n low width per channel
`define FREQ1_RESET         16'd400         // divider after reset

`endif

// File: verilog/adc_ifs.sv
// level signals only, no handshake on either interface
`timescale 1ns/1ps
`default_nettype none

// --------------------
// register block to acquisition control
interface acq_ctrl_if;
    import adc_pkg::*;

    word_t freq_div;                        // start period minus one
    logic  ad_enable;                       // enable level, edge used
    logic  ad_reset;                        // converter reset level
    logic  fifo_clr;                        // clear level
    logic  data_full;                       // all queues filled
    logic  work_en;                         // run in progress

    modport regs_mp (
        output freq_div, ad_enable, ad_reset, fifo_clr,
        input  data_full
    );

    modport ctrl_mp (
        input  freq_div, ad_enable, fifo_clr,
        output data_full, work_en
    );
endinterface

// --------------------
// one converter to its four queues
interface sample_if;
    import adc_pkg::*;

    chan_samples_t samples;                 // all lanes of one conversion
    logic          valid;                   // single-cycle strobe

    modport src_mp (output samples, valid);
    modport dst_mp (input  samples, valid);
endinterface

`default_nettype wire

// File: verilog/adc_pkg.sv
// shared data types for the acquisition front end, channel count comes from adc_defs.svh
`default_nettype none

`include "adc_defs.svh"

package adc_pkg;

    typedef logic [15:0] word_t;            // MCU bus word
    typedef logic [15:0] sample_t;          // one converter sample
    typedef logic [8:0]  addr_t;            // MCU byte address
    typedef logic [31:0] period_t;          // key-phase period in clocks

    // one conversion result, lane k is channel k of the chip
    typedef sample_t [`ADC_CHANS_PER_CHIP-1:0] chan_samples_t;

endpackage

`default_nettype wire

// File: verilog/adc_top.sv
// single clock AD_CLK_40M, the MCU data tristate sits outside using mcu_data_oe_o
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module adc_top (
    input  wire logic                  AD_CLK_40M,
    input  wire logic                  rst_n,
    input  wire logic                  mcu_cs_n_i,
    input  wire logic                  mcu_we_n_i,
    input  wire logic                  mcu_rd_n_i,
    input  wire adc_pkg::addr_t        mcu_addr_i,
    input  wire adc_pkg::word_t        mcu_data_i,
    output adc_pkg::word_t             mcu_data_o,
    output logic                       mcu_data_oe_o,
    input  wire adc_pkg::sample_t      adc_db0_i,
    input  wire adc_pkg::sample_t      adc_db1_i,
    input  wire logic [1:0]            adc_busy_i,
    output logic [1:0]                 adc_convst_a_o,
    output logic [1:0]                 adc_cs_n_o,
    output logic [1:0]                 adc_rd_n_o,
    output logic [1:0]                 adc_reset_o,
    input  wire logic                  phase_in_i
);
    import adc_pkg::*;

    localparam int N_CH = `ADC_CHIPS * `ADC_CHANS_PER_CHIP;

    acq_ctrl_if      u_ctrl_if ();
    sample_t         adc_db [`ADC_CHIPS];   // per-chip data bus
    sample_t         fifo_head [N_CH];
    logic [N_CH-1:0] fifo_empty;
    logic [N_CH-1:0] fifo_full;
    logic [N_CH-1:0] fifo_pop;
    period_t         period;
    logic            start;                 // shared conversion start

    assign adc_db[0] = adc_db0_i;
    assign adc_db[1] = adc_db1_i;

    mcu_bus_regs #(.N_CH(N_CH)) u_regs (
        .AD_CLK_40M   (AD_CLK_40M),
        .rst_n        (rst_n),
        .mcu_cs_n_i   (mcu_cs_n_i),
        .mcu_we_n_i   (mcu_we_n_i),
        .mcu_rd_n_i   (mcu_rd_n_i),
        .mcu_addr_i   (mcu_addr_i),
        .mcu_data_i   (mcu_data_i),
        .mcu_data_o   (mcu_data_o),
        .mcu_data_oe_o(mcu_data_oe_o),
        .ctrl         (u_ctrl_if.regs_mp),
        .fifo_head_i  (fifo_head),
        .fifo_empty_i (fifo_empty),
        .fifo_full_i  (fifo_full),
        .fifo_pop_o   (fifo_pop),
        .period_i     (period),
        .adc_reset_o  (adc_reset_o)
    );

    acq_ctrl #(.N_CH(N_CH)) u_acq (
        .AD_CLK_40M (AD_CLK_40M),
        .rst_n      (rst_n),
        .ctrl       (u_ctrl_if.ctrl_mp),
        .fifo_full_i(fifo_full),
        .start_o    (start)
    );

    // --------------------
    // converters and their queues
    for (genvar c = 0; c < `ADC_CHIPS; c++) begin : g_chip
        sample_if u_smp ();

        ad7606_reader u_reader (
            .AD_CLK_40M    (AD_CLK_40M),
            .rst_n         (rst_n),
            .start_i       (start),
            .adc_db_i      (adc_db[c]),
            .adc_busy_i    (adc_busy_i[c]),
            .adc_convst_a_o(adc_convst_a_o[c]),
            .adc_cs_n_o    (adc_cs_n_o[c]),
            .adc_rd_n_o    (adc_rd_n_o[c]),
            .out           (u_smp.src_mp)
        );

        for (genvar k = 0; k < `ADC_CHANS_PER_CHIP; k++) begin : g_lane
            sample_fifo u_fifo (
                .AD_CLK_40M(AD_CLK_40M),
                .rst_n     (rst_n),
                .clr_i     (u_ctrl_if.fifo_clr),
                .wr_i      (u_smp.valid),
                .din_i     (u_smp.samples[k]),
                .pop_i     (fifo_pop[c*`ADC_CHANS_PER_CHIP + k]),
                .head_o    (fifo_head[c*`ADC_CHANS_PER_CHIP + k]),
                .empty_o   (fifo_empty[c*`ADC_CHANS_PER_CHIP + k]),
                .full_o    (fifo_full[c*`ADC_CHANS_PER_CHIP + k])
            );
        end
    end

    phase_meter u_phase (
        .AD_CLK_40M(AD_CLK_40M),
        .rst_n     (rst_n),
        .phase_in_i(phase_in_i),
        .period_o  (period)
    );

endmodule

`default_nettype wire

// File: verilog/mcu_bus_regs.sv
// address must stay stable until the pop following rd_n rising, and reads are not cycle-registered
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module mcu_bus_regs #(
    parameter int N_CH = `ADC_CHIPS * `ADC_CHANS_PER_CHIP
) (
    input  wire logic                   AD_CLK_40M,
    input  wire logic                   rst_n,
    input  wire logic                   mcu_cs_n_i,
    input  wire logic                   mcu_we_n_i,
    input  wire logic                   mcu_rd_n_i,
    input  wire adc_pkg::addr_t         mcu_addr_i,
    input  wire adc_pkg::word_t         mcu_data_i,
    output adc_pkg::word_t              mcu_data_o,
    output logic                        mcu_data_oe_o,
    acq_ctrl_if.regs_mp                 ctrl,
    input  wire adc_pkg::sample_t       fifo_head_i [N_CH],
    input  wire logic [N_CH-1:0]        fifo_empty_i,
    input  wire logic [N_CH-1:0]        fifo_full_i,
    output logic [N_CH-1:0]             fifo_pop_o,
    input  wire adc_pkg::period_t       period_i,
    output logic [`ADC_CHIPS-1:0]       adc_reset_o
);
    import adc_pkg::*;

    logic       wr_stb;                     // write strobe this cycle
    logic [1:0] rd_hist;                    // [1] older rd_n sample
    logic       rd_rise;
    addr_t      ch_off;                     // offset from first data reg
    logic [2:0] ch_idx;
    logic       ch_sel;                     // address on a data reg
    logic       detect_error;
    word_t      rd_word;

    assign wr_stb       = !mcu_cs_n_i && !mcu_we_n_i;
    assign rd_rise      = !rd_hist[1] && rd_hist[0];   // read just ended
    assign ch_off       = mcu_addr_i - `ADDR_CH1_DATA;
    assign ch_idx       = ch_off[3:1];                  // two bytes per reg
    assign ch_sel       = (mcu_addr_i >= `ADDR_CH1_DATA) && (mcu_addr_i <= `ADDR_CH8_DATA)
                          && !mcu_addr_i[0];
    assign detect_error = (period_i == '0);             // no key-phase seen
    assign adc_reset_o  = {`ADC_CHIPS{ctrl.ad_reset}};  // same reset to both chips

    // --------------------
    // write decode
    always_ff @(posedge AD_CLK_40M) begin
        if (!rst_n) begin
            ctrl.freq_div  <= `FREQ1_RESET;
            ctrl.ad_enable <= 1'b0;
            ctrl.ad_reset  <= 1'b0;
            ctrl.fifo_clr  <= 1'b0;
        end else if (wr_stb) begin
            case (mcu_addr_i)
                `ADDR_FREQ1:     ctrl.freq_div  <= mcu_data_i;
                `ADDR_AD_ENABLE: ctrl.ad_enable <= mcu_data_i[0];
                `ADDR_AD_RESET:  ctrl.ad_reset  <= mcu_data_i[0];
                `ADDR_FIFO_CLR:  ctrl.fifo_clr  <= mcu_data_i[0];
                default: ;                                  // read-only or unmapped
            endcase
        end
    end

    // --------------------
    // read mux
    always_comb begin
        rd_word = '0;                                       // unmapped reads 0
        case (mcu_addr_i)
            `ADDR_VERSION:   rd_word = `REG_VERSION_VAL;
            `ADDR_FREQ1:     rd_word = ctrl.freq_div;
            `ADDR_PHASE_L:   rd_word = period_i[15:0];
            `ADDR_PHASE_H:   rd_word = period_i[31:16];
            `ADDR_AD_ENABLE: rd_word = {15'd0, ctrl.ad_enable};
            `ADDR_AD_RESET:  rd_word = {15'd0, ctrl.ad_reset};
            `ADDR_FIFO_CLR:  rd_word = {15'd0, ctrl.fifo_clr};
            `ADDR_STATUS:    rd_word = {{(16 - N_CH){1'b0}}, fifo_full_i};
            `ADDR_DATAFULL:  rd_word = {14'd0, detect_error, ctrl.data_full};
            default: begin
                if (ch_sel && !fifo_empty_i[ch_idx]) begin
                    rd_word = fifo_head_i[ch_idx];          // head of queue, 0 if empty
                end
            end
        endcase
    end

    assign mcu_data_oe_o = !mcu_cs_n_i && !mcu_rd_n_i;      // external tristate enable
    assign mcu_data_o    = rd_word;

    // --------------------
    // pop on rd_n rising, one cycle late
    always_ff @(posedge AD_CLK_40M) begin
        if (!rst_n) begin
            rd_hist    <= 2'b11;                            // bus idle high
            fifo_pop_o <= '0;
        end else begin
            rd_hist    <= {rd_hist[0], mcu_rd_n_i};
            fifo_pop_o <= '0;
            if (rd_rise && ch_sel) begin
                fifo_pop_o[ch_idx] <= 1'b1;
            end
        end
    end

    // at most one pop, and the address still on the popped queue
    a_pop_onehot: assert property (@(posedge AD_CLK_40M) disable iff (!rst_n)
        $onehot0(fifo_pop_o) && ((fifo_pop_o == '0) || (ch_sel && fifo_pop_o[ch_idx])));

endmodule

`default_nettype wire

// File: verilog/phase_meter.sv
// phase_in_i is asynchronous and must stay stable for more than two clocks per level
`timescale 1ns/1ps
`default_nettype none

module phase_meter (
    input  wire logic       AD_CLK_40M,
    input  wire logic       rst_n,
    input  wire logic       phase_in_i,
    output adc_pkg::period_t period_o
);
    import adc_pkg::*;

    logic [2:0] sync_q;                     // [1:0] synchronizer, [2] edge history
    logic       rise;
    logic       seen_edge;                  // first edge passed
    period_t    cnt;                        // clocks since last edge

    assign rise = sync_q[1] && !sync_q[2];

    always_ff @(posedge AD_CLK_40M) begin
        if (!rst_n) begin
            sync_q    <= '0;
            seen_edge <= 1'b0;
            cnt       <= '0;
            period_o  <= '0;                // reads 0 until second edge
        end else begin
            sync_q <= {sync_q[1:0], phase_in_i};
            if (rise) begin
                seen_edge <= 1'b1;
                cnt       <= period_t'(1);  // edge cycle counts as one
                if (seen_edge) period_o <= cnt;
            end else if (cnt != '1) begin
                cnt <= cnt + 1'b1;          // saturate at max
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sample_fifo.sv
// first-word-fall-through, DEPTH must be a power of two, writes to a full queue are lost
`timescale 1ns/1ps
`default_nettype none

`include "adc_defs.svh"

module sample_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  wire logic             AD_CLK_40M,
    input  wire logic             rst_n,
    input  wire logic             clr_i,
    input  wire logic             wr_i,
    input  wire adc_pkg::sample_t din_i,
    input  wire logic             pop_i,
    output adc_pkg::sample_t      head_o,
    output logic                  empty_o,
    output logic                  full_o
);
    import adc_pkg::*;

    localparam int AW = $clog2(DEPTH);

    sample_t       mem [DEPTH];             // payload store
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;                   // entries held
    logic          do_wr;
    logic          do_rd;

    assign empty_o = (count == '0);
    assign full_o  = (count == (AW + 1)'(DEPTH));
    assign do_wr   = wr_i && !full_o;
    assign do_rd   = pop_i && !empty_o;     // pop on empty ignored
    assign head_o  = mem[rd_ptr];

    always_ff @(posedge AD_CLK_40M) begin
        if (!rst_n || clr_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            count <= count + (AW + 1)'(do_wr) - (AW + 1)'(do_rd);
        end
    end

    always_ff @(posedge AD_CLK_40M) begin
        if (do_wr) mem[wr_ptr] <= din_i;
    end

    a_count_range: assert property (@(posedge AD_CLK_40M) disable iff (!rst_n)
        count <= (AW + 1)'(DEPTH));

endmodule

`default_nettype wire
